// ==== all.f ====
+incdir+test
src/dmaPkg.sv
src/dmaRegIf.sv
src/chanCtrlIf.sv
src/cpuBusPort.sv
src/channelRegs.sv
src/controlRegs.sv
src/dmaDatapath.sv
test/dmaTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dmaTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/dmaBusTasks.svh ====
`ifndef DMA_BUS_TASKS_SVH
`define DMA_BUS_TASKS_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic lfsrBit();
  logic feedback;
  feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
  lfsrState = {lfsrState[30:0], feedback};
  return feedback;
endfunction

// One LFSR step per bit taken
function automatic dmaPkg::word_t randomBits(input int count);
  dmaPkg::word_t value;
  value = '0;
  for (int i = 0; i < count; i++)
    value = {value[14:0], lfsrBit()};
  return value;
endfunction

// Strobes low for 3 cycles, then high for 2
task automatic busWrite(input dmaPkg::regAddr_t addr, input dmaPkg::dataByte_t data);
  @(posedge dma_if);
  csN    <= 1'b0;
  iowN   <= 1'b0;
  addrIn <= addr;
  dataIn <= data;
  repeat (3) @(posedge dma_if);
  csN  <= 1'b1;
  iowN <= 1'b1;
  @(posedge dma_if);
endtask

task automatic busRead(input dmaPkg::regAddr_t addr, output dmaPkg::dataByte_t data);
  @(posedge dma_if);
  csN    <= 1'b0;
  iorN   <= 1'b0;
  addrIn <= addr;
  repeat (3) @(posedge dma_if);
  csN  <= 1'b1;
  iorN <= 1'b1;
  // dataOut loaded at this edge, two edges after the sampled start
  @(negedge dma_if);
  data = dataOut;
  @(posedge dma_if);
endtask

// One-cycle step pulse whose outputs are taken half a cycle after it lands
task automatic pulseStep(input dmaPkg::channel_t chan, output dmaPkg::word_t addrSeen,
                         output logic [3:0] tcSeen);
  @(posedge dma_if);
  step        <= 1'b1;
  stepChannel <= chan;
  @(posedge dma_if);
  step <= 1'b0;
  @(negedge dma_if);
  addrSeen = addrOut;
  tcSeen   = tcOut;
endtask

`endif

// ==== test/dmaTb.sv ====
`default_nettype none

module dmaTb;

  localparam int          TimeoutCycles = 4000;
  localparam logic [31:0] LfsrSeed      = 32'h9d236dc0;

  logic              dma_if;
  logic              reset;
  logic              csN;
  logic              iorN;
  logic              iowN;
  dmaPkg::regAddr_t  addrIn;
  dmaPkg::dataByte_t dataIn;
  dmaPkg::dataByte_t dataOut;
  logic              step;
  dmaPkg::channel_t  stepChannel;
  dmaPkg::word_t     addrOut;
  logic [3:0]        tcOut;
  logic [3:0]        maskOut;

  logic [31:0] lfsrState;
  int          cycleCount = 0;

  // Reference model of the register file
  dmaPkg::word_t refBaseAddr  [dmaPkg::NumChannels];
  dmaPkg::word_t refBaseCount [dmaPkg::NumChannels];
  dmaPkg::word_t refCurAddr   [dmaPkg::NumChannels];
  dmaPkg::word_t refCurCount  [dmaPkg::NumChannels];
  dmaPkg::word_t refAddrOut;
  logic [3:0]    refAutoInit;
  logic [3:0]    refDecrement;
  logic [3:0]    refMask;
  logic [3:0]    refRequest;
  logic [3:0]    refTcStatus;
  logic          refDisabled;
  logic          refBytePtr;

  dmaDatapath u_dut (
    .dma_if      (dma_if),
    .reset       (reset),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .addrIn      (addrIn),
    .dataIn      (dataIn),
    .dataOut     (dataOut),
    .step        (step),
    .stepChannel (stepChannel),
    .addrOut     (addrOut),
    .tcOut       (tcOut),
    .maskOut     (maskOut)
  );

  `include "dmaBusTasks.svh"

  initial
  begin
    dma_if = 1'b0;
    forever #10 dma_if = ~dma_if;
  end

  always @(posedge dma_if)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles)
    begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic checkValue(input logic [15:0] got, input logic [15:0] expected,
                            input string what);
    assert (got === expected)
    else
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // State after reset or master clear
  task automatic clearModel();
    for (int i = 0; i < dmaPkg::NumChannels; i++)
    begin
      refBaseAddr[i]  = '0;
      refBaseCount[i] = '0;
      refCurAddr[i]   = '0;
      refCurCount[i]  = '0;
    end
    refAddrOut   = '0;
    refAutoInit  = '0;
    refDecrement = '0;
    refMask      = '1;
    refRequest   = '0;
    refTcStatus  = '0;
    refDisabled  = 1'b0;
    refBytePtr   = 1'b0;
  endtask

  task automatic writeReg(input dmaPkg::regAddr_t addr, input dmaPkg::dataByte_t data);
    dmaPkg::channel_t chan;
    busWrite(addr, data);
    chan = data[1:0];
    if (!addr[3])
    begin
      chan = addr[2:1];
      if (addr[0] && refBytePtr)
      begin
        refBaseCount[chan][15:8] = data;
        refCurCount[chan][15:8]  = data;
      end
      else if (addr[0])
      begin
        refBaseCount[chan][7:0] = data;
        refCurCount[chan][7:0]  = data;
      end
      else if (refBytePtr)
      begin
        refBaseAddr[chan][15:8] = data;
        refCurAddr[chan][15:8]  = data;
      end
      else
      begin
        refBaseAddr[chan][7:0] = data;
        refCurAddr[chan][7:0]  = data;
      end
      refBytePtr = !refBytePtr;
    end
    else
    begin
      case (addr)
        dmaPkg::AddrStatusCmd:   refDisabled = data[dmaPkg::CmdDisableBit];
        dmaPkg::AddrRequest:     refRequest[chan] = data[2];
        dmaPkg::AddrSingleMask:  refMask[chan] = data[2];
        dmaPkg::AddrMode:
        begin
          refAutoInit[chan]  = data[dmaPkg::ModeAutoInitBit];
          refDecrement[chan] = data[dmaPkg::ModeDecrementBit];
        end
        dmaPkg::AddrClearFf:     refBytePtr = 1'b0;
        dmaPkg::AddrMasterClear: clearModel();
        dmaPkg::AddrClearMask:   refMask = '0;
        dmaPkg::AddrAllMask:     refMask = data[3:0];
        default: ;
      endcase
    end
  endtask

  task automatic readReg(input dmaPkg::regAddr_t addr);
    dmaPkg::dataByte_t got;
    dmaPkg::dataByte_t expected;
    dmaPkg::word_t     word;
    busRead(addr, got);
    expected = '0;
    if (!addr[3])
    begin
      word = addr[0] ? refCurCount[addr[2:1]] : refCurAddr[addr[2:1]];
      expected = refBytePtr ? word[15:8] : word[7:0];
      refBytePtr = !refBytePtr;
    end
    else if (addr == dmaPkg::AddrStatusCmd)
    begin
      // Request bits high, TC bits low, TC cleared by the read
      expected = {refRequest, refTcStatus};
      refTcStatus = '0;
    end
    checkValue(16'(got), 16'(expected), $sformatf("dataOut of register %0d", addr));
  endtask

  task automatic stepChan(input dmaPkg::channel_t chan);
    dmaPkg::word_t addrSeen;
    logic [3:0]    tcSeen;
    logic [3:0]    tcExpected;
    pulseStep(chan, addrSeen, tcSeen);
    tcExpected = '0;
    if (!refMask[chan] && !refDisabled)
    begin
      refAddrOut = refCurAddr[chan];
      if (refCurCount[chan] == 16'h0000)
      begin
        tcExpected[chan]  = 1'b1;
        refTcStatus[chan] = 1'b1;
      end
      if (tcExpected[chan] && refAutoInit[chan])
      begin
        refCurAddr[chan]  = refBaseAddr[chan];
        refCurCount[chan] = refBaseCount[chan];
      end
      else
      begin
        refCurAddr[chan]  = refDecrement[chan] ? refCurAddr[chan] - 16'd1
                                               : refCurAddr[chan] + 16'd1;
        refCurCount[chan] = refCurCount[chan] - 16'd1;
      end
      if (tcExpected[chan] && !refAutoInit[chan])
        refMask[chan] = 1'b1;
    end
    checkValue(addrSeen, refAddrOut, "addrOut after step");
    checkValue(16'(tcSeen), 16'(tcExpected), "tcOut after step");
  endtask

  task automatic checkMask();
    @(negedge dma_if);
    checkValue(16'(maskOut), 16'(refMask), "maskOut");
  endtask

  function automatic dmaPkg::dataByte_t modeByte(input dmaPkg::channel_t chan,
                                                 input logic autoInit,
                                                 input logic decrement);
    dmaPkg::dataByte_t value;
    value = {6'b000000, chan};
    value[dmaPkg::ModeAutoInitBit]  = autoInit;
    value[dmaPkg::ModeDecrementBit] = decrement;
    return value;
  endfunction

  // Low byte then high byte, starting from a cleared pointer
  task automatic loadChannel(input dmaPkg::channel_t chan, input dmaPkg::word_t addr,
                             input dmaPkg::word_t count);
    dmaPkg::regAddr_t addrReg;
    addrReg = {1'b0, chan, 1'b0};
    writeReg(dmaPkg::AddrClearFf, 8'h00);
    writeReg(addrReg, addr[7:0]);
    writeReg(addrReg, addr[15:8]);
    writeReg(addrReg | 4'd1, count[7:0]);
    writeReg(addrReg | 4'd1, count[15:8]);
  endtask

  task automatic readChannel(input dmaPkg::channel_t chan);
    writeReg(dmaPkg::AddrClearFf, 8'h00);
    readReg({1'b0, chan, 1'b0});
    readReg({1'b0, chan, 1'b0});
    readReg({1'b0, chan, 1'b1});
    readReg({1'b0, chan, 1'b1});
  endtask

  task automatic checkIdle();
    checkMask();
    readReg(dmaPkg::AddrStatusCmd);
    readChannel(2'd1);
    stepChan(2'd0);
  endtask

  initial
  begin
    dmaPkg::channel_t chan;
    dmaPkg::word_t    count;
    reset       <= 1'b1;
    csN         <= 1'b1;
    iorN        <= 1'b1;
    iowN        <= 1'b1;
    addrIn      <= '0;
    dataIn      <= '0;
    step        <= 1'b0;
    stepChannel <= '0;
    lfsrState = LfsrSeed;
    clearModel();
    repeat (8) @(posedge dma_if);
    reset <= 1'b0;

    checkIdle();

    // Random base values on every channel, then readback
    for (int i = 0; i < dmaPkg::NumChannels; i++)
      loadChannel(dmaPkg::channel_t'(i), randomBits(16), randomBits(16));
    for (int i = 0; i < dmaPkg::NumChannels; i++)
      readChannel(dmaPkg::channel_t'(i));

    // Clearing the pointer mid-word restarts at the low byte
    writeReg(4'd0, dmaPkg::dataByte_t'(randomBits(8)));
    writeReg(dmaPkg::AddrClearFf, 8'h00);
    writeReg(4'd0, dmaPkg::dataByte_t'(randomBits(8)));
    writeReg(4'd0, dmaPkg::dataByte_t'(randomBits(8)));
    readChannel(2'd0);

    // Channel 0 counts up, channel 1 down
    for (int i = 0; i < 2; i++)
    begin
      chan = dmaPkg::channel_t'(i);
      writeReg(dmaPkg::AddrMode, modeByte(chan, 1'b0, chan[0]));
      writeReg(dmaPkg::AddrSingleMask, {6'b000000, chan});
      repeat (5) stepChan(chan);
      readChannel(chan);
    end

    // Terminal count without auto-initialize masks the channel
    count = randomBits(3);
    loadChannel(2'd2, randomBits(16), count);
    writeReg(dmaPkg::AddrMode, modeByte(2'd2, 1'b0, lfsrBit()));
    writeReg(dmaPkg::AddrSingleMask, 8'h02);
    repeat (int'(count) + 1) stepChan(2'd2);
    checkMask();
    readReg(dmaPkg::AddrStatusCmd);
    readReg(dmaPkg::AddrStatusCmd);

    // Terminal count with auto-initialize reloads the base values
    count = randomBits(3);
    loadChannel(2'd3, randomBits(16), count);
    writeReg(dmaPkg::AddrMode, modeByte(2'd3, 1'b1, lfsrBit()));
    writeReg(dmaPkg::AddrSingleMask, 8'h03);
    repeat (int'(count) + 1) stepChan(2'd3);
    checkMask();
    readReg(dmaPkg::AddrStatusCmd);
    readReg(dmaPkg::AddrStatusCmd);
    readChannel(2'd3);

    // Mask register writes
    writeReg(dmaPkg::AddrAllMask, dmaPkg::dataByte_t'(randomBits(4)));
    checkMask();
    writeReg(dmaPkg::AddrSingleMask, 8'h05);
    checkMask();
    writeReg(dmaPkg::AddrSingleMask, 8'h00);
    checkMask();
    writeReg(dmaPkg::AddrClearMask, 8'h00);
    checkMask();

    // Software requests show in status bits 7 to 4
    writeReg(dmaPkg::AddrRequest, 8'h05);
    writeReg(dmaPkg::AddrRequest, 8'h06);
    readReg(dmaPkg::AddrStatusCmd);
    writeReg(dmaPkg::AddrRequest, 8'h01);
    readReg(dmaPkg::AddrStatusCmd);

    // Disabled controller ignores steps
    writeReg(dmaPkg::AddrStatusCmd, 8'h04);
    stepChan(2'd0);
    stepChan(2'd0);
    readChannel(2'd0);
    writeReg(dmaPkg::AddrStatusCmd, 8'h00);
    stepChan(2'd0);

    writeReg(dmaPkg::AddrMasterClear, 8'h00);
    checkIdle();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/dmaDatapath.sv ====
`default_nettype none

module dmaDatapath (
  input  wire logic                      dma_if,
  input  wire logic                      reset,
  input  wire logic                      csN,
  input  wire logic                      iorN,
  input  wire logic                      iowN,
  input  wire dmaPkg::regAddr_t          addrIn,
  input  wire dmaPkg::dataByte_t         dataIn,
  output dmaPkg::dataByte_t              dataOut,
  input  wire logic                      step,
  input  wire dmaPkg::channel_t          stepChannel,
  output dmaPkg::word_t                  addrOut,
  output logic [dmaPkg::NumChannels-1:0] tcOut,
  output logic [dmaPkg::NumChannels-1:0] maskOut
);

  dmaRegIf   regIf ();
  chanCtrlIf ctlIf ();

  cpuBusPort busPort (
    .dma_if  (dma_if),
    .reset   (reset),
    .csN     (csN),
    .iorN    (iorN),
    .iowN    (iowN),
    .addrIn  (addrIn),
    .dataIn  (dataIn),
    .dataOut (dataOut),
    .regs    (regIf.bus)
  );

  channelRegs chanRegs (
    .dma_if      (dma_if),
    .reset       (reset),
    .step        (step),
    .stepChannel (stepChannel),
    .addrOut     (addrOut),
    .regs        (regIf.channel),
    .ctl         (ctlIf.chan)
  );

  controlRegs ctrlRegs (
    .dma_if  (dma_if),
    .reset   (reset),
    .maskOut (maskOut),
    .regs    (regIf.ctrl),
    .ctl     (ctlIf.ctrl)
  );

  // Terminal count leaves the chip as issued
  assign tcOut = ctlIf.tc;

endmodule

`default_nettype wire

// ==== src/controlRegs.sv ====
`default_nettype none

module controlRegs (
  input  wire logic                      dma_if,
  input  wire logic                      reset,
  output logic [dmaPkg::NumChannels-1:0] maskOut,
  dmaRegIf.ctrl                          regs,
  chanCtrlIf.ctrl                        ctl
);

  dmaPkg::dataByte_t              modeReg [dmaPkg::NumChannels];
  dmaPkg::dataByte_t              command;
  logic [dmaPkg::NumChannels-1:0] request;
  logic [dmaPkg::NumChannels-1:0] mask;
  logic [dmaPkg::NumChannels-1:0] maskNext;
  logic [dmaPkg::NumChannels-1:0] tcStatus;
  dmaPkg::channel_t               selChan;

  // Mode, request and single mask all carry the channel in bits 1:0
  assign selChan = regs.wrData[1:0];

  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear)
    begin
      for (int i = 0; i < dmaPkg::NumChannels; i++)
        modeReg[i] <= '0;
      command <= '0;
      request <= '0;
    end
    else
    begin
      if (regs.wrMode)
        modeReg[selChan] <= regs.wrData;
      if (regs.wrCommand)
        command <= regs.wrData;
      if (regs.wrRequest)
        request[selChan] <= regs.wrData[2];
    end
  end

  always_comb
  begin
    maskNext = mask;
    if (regs.wrSingleMask)
      maskNext[selChan] = regs.wrData[2];
    if (regs.wrAllMask)
      maskNext = regs.wrData[3:0];
    if (regs.clearMask)
      maskNext = '0;
    // Channel without auto-initialize stops at terminal count
    maskNext = maskNext | (ctl.tc & ~ctl.autoInit);
  end

  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear)
      mask <= '1;
    else
      mask <= maskNext;
  end

  // New terminal count wins over the read clear
  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear)
      tcStatus <= '0;
    else
      tcStatus <= (regs.statusRead ? '0 : tcStatus) | ctl.tc;
  end

  always_comb
  begin
    for (int i = 0; i < dmaPkg::NumChannels; i++)
    begin
      ctl.autoInit[i]  = modeReg[i][dmaPkg::ModeAutoInitBit];
      ctl.decrement[i] = modeReg[i][dmaPkg::ModeDecrementBit];
    end
  end

  assign ctl.mask        = mask;
  assign ctl.disabled    = command[dmaPkg::CmdDisableBit];
  assign maskOut         = mask;
  assign regs.statusByte = {request, tcStatus};

  assert property (@(posedge dma_if) disable iff (reset)
    regs.masterClear |-> !(regs.wrChanReg || regs.wrMode || regs.wrCommand ||
                           regs.wrRequest || regs.wrSingleMask || regs.wrAllMask ||
                           regs.clearMask));

endmodule

`default_nettype wire

// ==== src/channelRegs.sv ====
`default_nettype none

module channelRegs (
  input  wire logic             dma_if,
  input  wire logic             reset,
  input  wire logic             step,
  input  wire dmaPkg::channel_t stepChannel,
  output dmaPkg::word_t         addrOut,
  dmaRegIf.channel              regs,
  chanCtrlIf.chan               ctl
);

  dmaPkg::word_t baseAddr  [dmaPkg::NumChannels];
  dmaPkg::word_t baseCount [dmaPkg::NumChannels];
  dmaPkg::word_t curAddr   [dmaPkg::NumChannels];
  dmaPkg::word_t curCount  [dmaPkg::NumChannels];

  logic          stepOk;
  logic          atTc;
  dmaPkg::word_t nextAddr;

  // Masked channels and a disabled controller ignore steps
  assign stepOk = step && !ctl.mask[stepChannel] && !ctl.disabled;
  assign atTc   = (curCount[stepChannel] == '0);

  assign nextAddr = ctl.decrement[stepChannel] ? curAddr[stepChannel] - 16'd1
                                               : curAddr[stepChannel] + 16'd1;

  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear)
    begin
      for (int i = 0; i < dmaPkg::NumChannels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddr[i]   <= '0;
        curCount[i]  <= '0;
      end
      addrOut <= '0;
      ctl.tc  <= '0;
    end
    else
    begin
      ctl.tc <= '0;
      if (stepOk)
      begin
        addrOut <= curAddr[stepChannel];
        if (atTc)
          ctl.tc[stepChannel] <= 1'b1;
        // Auto-initialize reloads instead of wrapping
        if (atTc && ctl.autoInit[stepChannel])
        begin
          curAddr[stepChannel]  <= baseAddr[stepChannel];
          curCount[stepChannel] <= baseCount[stepChannel];
        end
        else
        begin
          curAddr[stepChannel]  <= nextAddr;
          curCount[stepChannel] <= curCount[stepChannel] - 16'd1;
        end
      end

      // CPU byte writes go to base and current alike
      if (regs.wrChanReg)
      begin
        if (regs.wordSel)
        begin
          if (regs.highByte)
          begin
            baseCount[regs.chan][15:8] <= regs.wrData;
            curCount[regs.chan][15:8]  <= regs.wrData;
          end
          else
          begin
            baseCount[regs.chan][7:0] <= regs.wrData;
            curCount[regs.chan][7:0]  <= regs.wrData;
          end
        end
        else
        begin
          if (regs.highByte)
          begin
            baseAddr[regs.chan][15:8] <= regs.wrData;
            curAddr[regs.chan][15:8]  <= regs.wrData;
          end
          else
          begin
            baseAddr[regs.chan][7:0] <= regs.wrData;
            curAddr[regs.chan][7:0]  <= regs.wrData;
          end
        end
      end
    end
  end

  // Readback of current address or count
  assign regs.chanWord = regs.wordSel ? curCount[regs.chan] : curAddr[regs.chan];

  assert property (@(posedge dma_if) disable iff (reset) $onehot0(ctl.tc));

  // A tc pulse belongs to the channel stepped one cycle before
  assert property (@(posedge dma_if) disable iff (reset)
    (ctl.tc != '0) |-> ($past(stepOk) && ctl.tc[$past(stepChannel)]));

endmodule

`default_nettype wire

// ==== src/cpuBusPort.sv ====
`default_nettype none

module cpuBusPort (
  input  wire logic              dma_if,
  input  wire logic              reset,
  input  wire logic              csN,
  input  wire logic              iorN,
  input  wire logic              iowN,
  input  wire dmaPkg::regAddr_t  addrIn,
  input  wire dmaPkg::dataByte_t dataIn,
  output dmaPkg::dataByte_t      dataOut,
  dmaRegIf.bus                   regs
);

  // Sampled CPU pins
  logic              csQ;
  logic              iorQ;
  logic              iowQ;
  dmaPkg::regAddr_t  addrQ;
  dmaPkg::dataByte_t dataQ;
  logic              accessPrev;

  logic accessNow;
  logic started;
  logic isWrite;
  logic isRead;

  // Address of the access in progress
  dmaPkg::regAddr_t accAddr;
  logic             rdStb;
  logic             clearFf;
  logic             chanAccess;

  always_ff @(posedge dma_if)
  begin
    if (reset)
    begin
      csQ        <= 1'b1;
      iorQ       <= 1'b1;
      iowQ       <= 1'b1;
      accessPrev <= 1'b0;
    end
    else
    begin
      csQ        <= csN;
      iorQ       <= iorN;
      iowQ       <= iowN;
      accessPrev <= accessNow;
    end
  end

  always_ff @(posedge dma_if)
  begin
    addrQ <= addrIn;
    dataQ <= dataIn;
  end

  // Only the first sampled cycle of a strobe counts
  assign accessNow = !csQ && (!iorQ || !iowQ);
  assign started   = accessNow && !accessPrev;
  assign isWrite   = started && !iowQ;
  assign isRead    = started && iowQ && !iorQ;

  always_ff @(posedge dma_if)
  begin
    if (reset)
    begin
      regs.wrChanReg    <= 1'b0;
      regs.wrCommand    <= 1'b0;
      regs.wrRequest    <= 1'b0;
      regs.wrSingleMask <= 1'b0;
      regs.wrMode       <= 1'b0;
      regs.wrAllMask    <= 1'b0;
      regs.clearMask    <= 1'b0;
      regs.masterClear  <= 1'b0;
      regs.statusRead   <= 1'b0;
      clearFf           <= 1'b0;
      rdStb             <= 1'b0;
      chanAccess        <= 1'b0;
    end
    else
    begin
      regs.wrChanReg    <= isWrite && !addrQ[3];
      regs.wrCommand    <= isWrite && (addrQ == dmaPkg::AddrStatusCmd);
      regs.wrRequest    <= isWrite && (addrQ == dmaPkg::AddrRequest);
      regs.wrSingleMask <= isWrite && (addrQ == dmaPkg::AddrSingleMask);
      regs.wrMode       <= isWrite && (addrQ == dmaPkg::AddrMode);
      regs.wrAllMask    <= isWrite && (addrQ == dmaPkg::AddrAllMask);
      regs.clearMask    <= isWrite && (addrQ == dmaPkg::AddrClearMask);
      regs.masterClear  <= isWrite && (addrQ == dmaPkg::AddrMasterClear);
      regs.statusRead   <= isRead && (addrQ == dmaPkg::AddrStatusCmd);
      clearFf           <= isWrite && (addrQ == dmaPkg::AddrClearFf);
      rdStb             <= isRead;
      chanAccess        <= started && !addrQ[3];
    end
  end

  always_ff @(posedge dma_if)
  begin
    if (started)
    begin
      accAddr     <= addrQ;
      regs.wrData <= dataQ;
    end
  end

  // Channel registers at 2n and 2n+1
  assign regs.chan    = accAddr[2:1];
  assign regs.wordSel = accAddr[0];

  // Byte pointer, low byte first
  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear || clearFf)
      regs.highByte <= 1'b0;
    else if (chanAccess)
      regs.highByte <= !regs.highByte;
  end

  always_ff @(posedge dma_if)
  begin
    if (reset || regs.masterClear)
      dataOut <= '0;
    else if (rdStb)
    begin
      if (!accAddr[3])
        dataOut <= regs.highByte ? regs.chanWord[15:8] : regs.chanWord[7:0];
      else if (accAddr == dmaPkg::AddrStatusCmd)
        dataOut <= regs.statusByte;
      else
        dataOut <= '0;
    end
  end

  // One register action per access
  assert property (@(posedge dma_if) disable iff (reset)
    $onehot0({regs.wrChanReg, regs.wrCommand, regs.wrRequest, regs.wrSingleMask,
              regs.wrMode, regs.wrAllMask, regs.clearMask, regs.masterClear,
              regs.statusRead, clearFf}));

endmodule

`default_nettype wire

// ==== src/chanCtrlIf.sv ====
`default_nettype none

interface chanCtrlIf;

  // Per-channel settings from the control block
  logic [dmaPkg::NumChannels-1:0] autoInit;
  logic [dmaPkg::NumChannels-1:0] decrement;
  logic [dmaPkg::NumChannels-1:0] mask;
  logic                           disabled;

  // Terminal-count pulses from the channel block
  logic [dmaPkg::NumChannels-1:0] tc;

  modport ctrl (
    output autoInit, decrement, mask, disabled,
    input  tc
  );

  modport chan (
    input  autoInit, decrement, mask, disabled,
    output tc
  );

endinterface

`default_nettype wire

// ==== src/dmaRegIf.sv ====
`default_nettype none

interface dmaRegIf;

  // Access payload held for the length of one access
  dmaPkg::dataByte_t wrData;
  dmaPkg::channel_t  chan;
  logic              highByte;
  logic              wordSel;

  // Decoded single-cycle strobes
  logic wrChanReg;
  logic wrMode;
  logic wrCommand;
  logic wrRequest;
  logic wrSingleMask;
  logic wrAllMask;
  logic clearMask;
  logic masterClear;
  logic statusRead;

  // Read sources
  dmaPkg::word_t     chanWord;
  dmaPkg::dataByte_t statusByte;

  modport bus (
    output wrData, chan, highByte, wordSel,
    output wrChanReg, wrMode, wrCommand, wrRequest, wrSingleMask,
    output wrAllMask, clearMask, masterClear, statusRead,
    input  chanWord, statusByte
  );

  modport channel (
    input  wrData, chan, highByte, wordSel, wrChanReg, masterClear,
    output chanWord
  );

  modport ctrl (
    input  wrData, wrChanReg, wrMode, wrCommand, wrRequest, wrSingleMask,
    input  wrAllMask, clearMask, masterClear, statusRead,
    output statusByte
  );

endinterface

`default_nettype wire

// ==== src/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

  // CPU data byte and register address
  typedef logic [7:0]  dataByte_t;
  typedef logic [3:0]  regAddr_t;

  // Address and count registers
  typedef logic [15:0] word_t;
  typedef logic [1:0]  channel_t;

  localparam int NumChannels = 4;

  // Control register addresses
  // Channel n has its address at 2n and its count at 2n+1
  localparam regAddr_t AddrStatusCmd   = 4'd8;
  localparam regAddr_t AddrRequest     = 4'd9;
  localparam regAddr_t AddrSingleMask  = 4'd10;
  localparam regAddr_t AddrMode        = 4'd11;
  localparam regAddr_t AddrClearFf     = 4'd12;
  localparam regAddr_t AddrMasterClear = 4'd13;
  localparam regAddr_t AddrClearMask   = 4'd14;
  localparam regAddr_t AddrAllMask     = 4'd15;

  // Mode byte fields
  // Bits 1:0 of the mode byte pick the channel
  localparam int ModeAutoInitBit  = 4;
  localparam int ModeDecrementBit = 5;

  // Command byte
  localparam int CmdDisableBit = 2;

endpackage

`default_nettype wire
